// File: tb.f
+incdir+hw
+incdir+testbench
hw/iq_pkg.sv
hw/iq_bank.sv
hw/iq_dual_queue.sv
hw/iq_push_handshake.sv
hw/id_queue_top.sv
testbench/tb_id_queue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the queue testbench with Verilator, run it and grade the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
    --top-module tb_id_queue --Mdir obj_dir -o tb_id_queue \
    && ./obj_dir/tb_id_queue 2>&1 | tee sim.log

grep -q "ALL CHECKS PASSED" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: testbench/tb_queue_model.svh
`ifndef TB_QUEUE_MODEL_SVH
`define TB_QUEUE_MODEL_SVH

// one instruction as it travels through the queue
typedef struct packed {
    iq_pkg::pc_t     pc;
    iq_pkg::ir_t     ir;
    iq_pkg::brinfo_t br;
    iq_pkg::ecode_t  ecode;
} entry_t;

// program order, oldest at index 0
entry_t model_q[$];

logic [31:0] rng_state = 32'd39;

////////////////////
// xorshift32
////////////////////
function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

function automatic int rand_below(int n);
    return int'(next_rand() % n);
endfunction

function automatic entry_t random_entry();
    entry_t e;
    logic [31:0] r;
    r = next_rand();
    // word aligned pc
    e.pc = {r[31:2], 2'b00};
    e.ir = next_rand();
    r = next_rand();
    e.br = {r[1:0], next_rand()};
    e.ecode = r[15:8];
    return e;
endfunction

// issue takes everything shown, at most two
function automatic int model_pop_shown();
    int n;
    n = (model_q.size() >= 2) ? 2 : model_q.size();
    for (int i = 0; i < n; i++) begin
        void'(model_q.pop_front());
    end
    return n;
endfunction

function automatic logic [1:0] model_valid();
    if (model_q.size() >= 2) begin
        return 2'b11;
    end
    if (model_q.size() == 1) begin
        return 2'b10;
    end
    return 2'b00;
endfunction

`endif

// File: testbench/tb_id_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_params.svh"

module tb_id_queue;

`include "tb_queue_model.svh"

    // all phases together take about 2000 cycles
    localparam int MAX_CYCLES = 4000;

    logic            clk;
    logic            rstn;
    logic            i_req;
    logic            o_ack;
    logic [1:0]      i_valid;
    logic            i_stall;
    logic            i_flush;
    entry_t          lane1;
    entry_t          lane2;
    iq_pkg::pc_t     o_pc1, o_pc2;
    iq_pkg::ir_t     o_ir1, o_ir2;
    iq_pkg::brinfo_t o_brinfo1, o_brinfo2;
    iq_pkg::ecode_t  o_ecode1, o_ecode2;
    logic [1:0]      o_valid;

    int cycles = 0;
    int errors = 0;
    int accepted = 0;
    int popped = 0;
    int flushed = 0;
    int stall_pct;
    int pair_pct;
    int gap_max;
    int gap_left;
    int flush_left;
    logic issue_en;
    logic flush_en;
    logic pending;
    logic force_single;
    logic single_after_flush;
    logic prev_ack;
    logic [1:0] prev_valid;
    iq_pkg::pc_t prev_pc1;
    iq_pkg::ir_t prev_ir1;

    id_queue_top dut0 (
        .clk       (clk),
        .rstn      (rstn),
        .i_req     (i_req),
        .o_ack     (o_ack),
        .i_valid   (i_valid),
        .i_pc1     (lane1.pc),
        .i_ir1     (lane1.ir),
        .i_brinfo1 (lane1.br),
        .i_ecode1  (lane1.ecode),
        .i_pc2     (lane2.pc),
        .i_ir2     (lane2.ir),
        .i_brinfo2 (lane2.br),
        .i_ecode2  (lane2.ecode),
        .i_stall   (i_stall),
        .i_flush   (i_flush),
        .o_pc1     (o_pc1),
        .o_ir1     (o_ir1),
        .o_brinfo1 (o_brinfo1),
        .o_ecode1  (o_ecode1),
        .o_pc2     (o_pc2),
        .o_ir2     (o_ir2),
        .o_brinfo2 (o_brinfo2),
        .o_ecode2  (o_ecode2),
        .o_valid   (o_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the queue did not drain in time", cycles);
            fail_run();
        end
    end

    ////////////////////
    // reporting
    ////////////////////
    task automatic fail_run();
        errors++;
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_field(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        assert (act_v === exp_v) else begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, exp_v, act_v);
            fail_run();
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("ERROR time=%0t %s", $time, what);
            fail_run();
        end
    endtask

    task automatic check_lane(input string sfx, input entry_t exp_e, input entry_t act_e);
        check_field({"o_pc", sfx}, 64'(exp_e.pc), 64'(act_e.pc));
        check_field({"o_ir", sfx}, 64'(exp_e.ir), 64'(act_e.ir));
        check_field({"o_brinfo", sfx}, 64'(exp_e.br), 64'(act_e.br));
        check_field({"o_ecode", sfx}, 64'(exp_e.ecode), 64'(act_e.ecode));
    endtask

    ////////////////////
    // per-cycle model update and compare
    ////////////////////
    // i_* still hold the values the DUT sampled at this edge
    task automatic observe();
        if (i_flush) begin
            flushed += model_q.size();
            model_q.delete();
        end else if (!i_stall) begin
            // entries the DUT showed before this edge are gone now
            popped += int'(prev_valid[1]) + int'(prev_valid[0]);
            void'(model_pop_shown());
        end
        if (o_ack && !prev_ack) begin
            check_true(i_req, "ack rose while req was low");
            check_true(pending, "ack rose twice for the same pair");
            // each bank below 15 entries when the pair was taken
            check_true(model_q.size() <= 2 * (`IQ_BANK_DEPTH - 2),
                       "pair accepted while the queue was full");
            pending = 1'b0;
            model_q.push_back(lane1);
            accepted++;
            if (i_valid == 2'b11) begin
                model_q.push_back(lane2);
                accepted++;
            end
            if (single_after_flush) begin
                check_true(o_valid == 2'b10 && o_pc1 == lane1.pc,
                           "first entry after a flush is not alone on lane 1");
                single_after_flush = 1'b0;
            end
        end
        if (!o_ack && prev_ack) begin
            check_true(!i_req, "ack fell while req was still high");
        end
        if (i_flush) begin
            check_field("o_valid", 64'(2'b00), 64'(o_valid));
        end
        // stalled head must not move
        if (i_stall && !i_flush && prev_valid[1]) begin
            check_field("o_pc1", 64'(prev_pc1), 64'(o_pc1));
            check_field("o_ir1", 64'(prev_ir1), 64'(o_ir1));
        end
        check_field("o_valid", 64'(model_valid()), 64'(o_valid));
        if (model_q.size() >= 1) begin
            check_lane("1", model_q[0], {o_pc1, o_ir1, o_brinfo1, o_ecode1});
        end
        if (model_q.size() >= 2) begin
            check_lane("2", model_q[1], {o_pc2, o_ir2, o_brinfo2, o_ecode2});
        end
        prev_ack = o_ack;
        prev_valid = o_valid;
        prev_pc1 = o_pc1;
        prev_ir1 = o_ir1;
    endtask

    ////////////////////
    // stimulus, four-phase master
    ////////////////////
    task automatic drive();
        i_flush = 1'b0;
        i_stall = (rand_below(100) < stall_pct);
        if (flush_left > 0) begin
            flush_left--;
        end
        // flush only with the handshake idle
        if (flush_en && flush_left == 0 && !i_req && !o_ack) begin
            i_flush = 1'b1;
            force_single = 1'b1;
            flush_left = 120 + rand_below(60);
        end
        if (i_req && o_ack) begin
            i_req = 1'b0;
        end else if (!i_req && !o_ack && !i_flush) begin
            if (gap_left > 0) begin
                gap_left--;
            end else if (issue_en) begin
                lane1 = random_entry();
                lane2 = random_entry();
                i_valid = (force_single || rand_below(100) >= pair_pct) ? 2'b10 : 2'b11;
                single_after_flush = force_single;
                force_single = 1'b0;
                i_req = 1'b1;
                pending = 1'b1;
                gap_left = rand_below(gap_max + 1);
            end
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
        observe();
        drive();
    endtask

    task automatic set_mode(input int stall_p, input int pair_p, input int gap_m);
        stall_pct = stall_p;
        pair_pct = pair_p;
        gap_max = gap_m;
    endtask

    // stop fetch and let issue empty the queue
    task automatic drain();
        issue_en = 1'b0;
        flush_en = 1'b0;
        set_mode(0, 0, 0);
        step();
        while (!(o_valid == 2'b00 && !i_req && !o_ack)) begin
            step();
        end
        check_true(accepted == popped + flushed, "entries were lost or duplicated");
    endtask

    initial begin
        rstn = 1'b0;
        i_req = 1'b0;
        i_valid = 2'b00;
        i_stall = 1'b0;
        i_flush = 1'b0;
        lane1 = '0;
        lane2 = '0;
        issue_en = 1'b0;
        flush_en = 1'b0;
        pending = 1'b0;
        force_single = 1'b0;
        single_after_flush = 1'b0;
        prev_ack = 1'b0;
        prev_valid = 2'b00;
        prev_pc1 = '0;
        prev_ir1 = '0;
        gap_left = 0;
        flush_left = 150;
        set_mode(0, 0, 0);
        repeat (10) @(posedge clk);
        #1;
        check_true(o_ack == 1'b0 && o_valid == 2'b00, "outputs not idle after reset");
        rstn = 1'b1;

        // mixed singles and pairs, random stall, periodic flush
        issue_en = 1'b1;
        flush_en = 1'b1;
        set_mode(25, 60, 3);
        repeat (1000) step();

        // issue stalled while fetch keeps pushing pairs
        flush_en = 1'b0;
        set_mode(100, 100, 0);
        repeat (120) step();
        check_true(model_q.size() >= 29, "queue never filled up under stall");
        check_true(pending && !o_ack, "fetch was not held off while the queue was full");
        drain();

        // heavy stall, mostly singles
        issue_en = 1'b1;
        flush_en = 1'b1;
        flush_left = 60;
        set_mode(60, 30, 2);
        repeat (800) step();
        drain();

        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/id_queue_top.sv
`timescale 1ns/1ps
`default_nettype none

module id_queue_top (
    input  wire logic            clk,
    input  wire logic            rstn,

    // fetch side, four-phase
    input  wire logic            i_req,
    output logic                 o_ack,
    input  wire logic [1:0]      i_valid,
    input  wire iq_pkg::pc_t     i_pc1,
    input  wire iq_pkg::ir_t     i_ir1,
    input  wire iq_pkg::brinfo_t i_brinfo1,
    input  wire iq_pkg::ecode_t  i_ecode1,
    input  wire iq_pkg::pc_t     i_pc2,
    input  wire iq_pkg::ir_t     i_ir2,
    input  wire iq_pkg::brinfo_t i_brinfo2,
    input  wire iq_pkg::ecode_t  i_ecode2,

    // issue and branch resolution
    input  wire logic            i_stall,
    input  wire logic            i_flush,

    output iq_pkg::pc_t          o_pc1,
    output iq_pkg::ir_t          o_ir1,
    output iq_pkg::brinfo_t      o_brinfo1,
    output iq_pkg::ecode_t       o_ecode1,
    output iq_pkg::pc_t          o_pc2,
    output iq_pkg::ir_t          o_ir2,
    output iq_pkg::brinfo_t      o_brinfo2,
    output iq_pkg::ecode_t       o_ecode2,
    output logic [1:0]           o_valid
);

    logic push;
    logic full;

    iq_push_handshake hs0 (
        .clk     (clk),
        .rstn    (rstn),
        .i_req   (i_req),
        .i_full  (full),
        .i_flush (i_flush),
        .o_ack   (o_ack),
        .o_push  (push)
    );

    // pair fields go straight in, the push pulse qualifies them
    iq_dual_queue q0 (
        .clk       (clk),
        .rstn      (rstn),
        .i_push    (push),
        .i_valid   (i_valid),
        .i_pc1     (i_pc1),
        .i_ir1     (i_ir1),
        .i_brinfo1 (i_brinfo1),
        .i_ecode1  (i_ecode1),
        .i_pc2     (i_pc2),
        .i_ir2     (i_ir2),
        .i_brinfo2 (i_brinfo2),
        .i_ecode2  (i_ecode2),
        .i_stall   (i_stall),
        .i_flush   (i_flush),
        .o_full    (full),
        .o_pc1     (o_pc1),
        .o_ir1     (o_ir1),
        .o_brinfo1 (o_brinfo1),
        .o_ecode1  (o_ecode1),
        .o_pc2     (o_pc2),
        .o_ir2     (o_ir2),
        .o_brinfo2 (o_brinfo2),
        .o_ecode2  (o_ecode2),
        .o_valid   (o_valid)
    );

endmodule

`default_nettype wire

// File: hw/iq_push_handshake.sv
`timescale 1ns/1ps
`default_nettype none

module iq_push_handshake (
    input  wire logic clk,
    input  wire logic rstn,
    input  wire logic i_req,
    input  wire logic i_full,
    input  wire logic i_flush,
    output logic      o_ack,
    output logic      o_push
);

    iq_pkg::hs_state_e state;
    iq_pkg::hs_state_e state_nxt;

    ////////////////////
    // four-phase slave
    ////////////////////
    // HS_ACK is the single accept cycle that pushes the pair,
    // HS_WAIT_LOW holds ack until the master drops req
    always_comb begin
        state_nxt = state;
        case (state)
            iq_pkg::HS_IDLE: begin
                // no room means no ack, fetch just waits
                if (i_req && !i_full && !i_flush) begin
                    state_nxt = iq_pkg::HS_ACK;
                end
            end
            iq_pkg::HS_ACK: begin
                state_nxt = iq_pkg::HS_WAIT_LOW;
            end
            iq_pkg::HS_WAIT_LOW: begin
                if (!i_req) begin
                    state_nxt = iq_pkg::HS_IDLE;
                end
            end
            default: begin
                state_nxt = iq_pkg::HS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= iq_pkg::HS_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // pair data is still held stable by the master here
    assign o_push = (state == iq_pkg::HS_ACK);

    // rises one edge after the push cycle
    assign o_ack  = (state == iq_pkg::HS_WAIT_LOW);

endmodule

`default_nettype wire

// File: hw/iq_dual_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_params.svh"

module iq_dual_queue (
    input  wire logic            clk,
    input  wire logic            rstn,

    input  wire logic            i_push,
    input  wire logic [1:0]      i_valid,
    input  wire iq_pkg::pc_t     i_pc1,
    input  wire iq_pkg::ir_t     i_ir1,
    input  wire iq_pkg::brinfo_t i_brinfo1,
    input  wire iq_pkg::ecode_t  i_ecode1,
    input  wire iq_pkg::pc_t     i_pc2,
    input  wire iq_pkg::ir_t     i_ir2,
    input  wire iq_pkg::brinfo_t i_brinfo2,
    input  wire iq_pkg::ecode_t  i_ecode2,

    input  wire logic            i_stall,
    input  wire logic            i_flush,

    output logic                 o_full,
    output iq_pkg::pc_t          o_pc1,
    output iq_pkg::ir_t          o_ir1,
    output iq_pkg::brinfo_t      o_brinfo1,
    output iq_pkg::ecode_t       o_ecode1,
    output iq_pkg::pc_t          o_pc2,
    output iq_pkg::ir_t          o_ir2,
    output iq_pkg::brinfo_t      o_brinfo2,
    output iq_pkg::ecode_t       o_ecode2,
    output logic [1:0]           o_valid
);

    // one slot kept free so a pair always fits
    localparam iq_pkg::cnt_t FULL_LVL = iq_pkg::cnt_t'(`IQ_BANK_DEPTH - 1);

    // 0: bank a takes the next lone instruction
    logic in_sel;
    // 0: oldest entry sits at the tail of bank a
    logic out_sel;

    logic push_pair;
    logic push_single;
    logic wr_a;
    logic wr_b;
    logic rd_a;
    logic rd_b;
    logic a_busy;
    logic b_busy;

    iq_pkg::cnt_t    a_count;
    iq_pkg::cnt_t    b_count;
    iq_pkg::pc_t     a_pc;
    iq_pkg::ir_t     a_ir;
    iq_pkg::brinfo_t a_br;
    iq_pkg::ecode_t  a_ecode;
    iq_pkg::pc_t     b_pc;
    iq_pkg::ir_t     b_ir;
    iq_pkg::brinfo_t b_br;
    iq_pkg::ecode_t  b_ecode;

    ////////////////////
    // input steering
    ////////////////////
    assign push_pair   = i_push && !i_flush && (i_valid == 2'b11);
    assign push_single = i_push && !i_flush && (i_valid == 2'b10);

    assign wr_a = push_pair || (push_single && !in_sel);
    assign wr_b = push_pair || (push_single && in_sel);

    ////////////////////
    // read side
    ////////////////////
    assign a_busy = (a_count != '0);
    assign b_busy = (b_count != '0);

    // whatever is shown leaves unless issue stalls
    assign rd_a = a_busy && !i_stall;
    assign rd_b = b_busy && !i_stall;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            in_sel  <= 1'b0;
            out_sel <= 1'b0;
        end else if (i_flush) begin
            in_sel  <= 1'b0;
            out_sel <= 1'b0;
        end else begin
            if (push_single) begin
                in_sel <= ~in_sel;
            end
            // odd number popped, oldest moves to the other bank
            if (rd_a != rd_b) begin
                out_sel <= ~out_sel;
            end
        end
    end

    // lane 1 of a pair lands in the bank named by in_sel
    iq_bank bank_a (
        .clk        (clk),
        .rstn       (rstn),
        .i_flush    (i_flush),
        .i_wr       (wr_a),
        .i_wr_pc    (in_sel ? i_pc2     : i_pc1),
        .i_wr_ir    (in_sel ? i_ir2     : i_ir1),
        .i_wr_br    (in_sel ? i_brinfo2 : i_brinfo1),
        .i_wr_ecode (in_sel ? i_ecode2  : i_ecode1),
        .i_rd       (rd_a),
        .o_rd_pc    (a_pc),
        .o_rd_ir    (a_ir),
        .o_rd_br    (a_br),
        .o_rd_ecode (a_ecode),
        .o_count    (a_count)
    );

    iq_bank bank_b (
        .clk        (clk),
        .rstn       (rstn),
        .i_flush    (i_flush),
        .i_wr       (wr_b),
        .i_wr_pc    (in_sel ? i_pc1     : i_pc2),
        .i_wr_ir    (in_sel ? i_ir1     : i_ir2),
        .i_wr_br    (in_sel ? i_brinfo1 : i_brinfo2),
        .i_wr_ecode (in_sel ? i_ecode1  : i_ecode2),
        .i_rd       (rd_b),
        .o_rd_pc    (b_pc),
        .o_rd_ir    (b_ir),
        .o_rd_br    (b_br),
        .o_rd_ecode (b_ecode),
        .o_count    (b_count)
    );

    ////////////////////
    // output ordering
    ////////////////////
    assign o_pc1     = out_sel ? b_pc    : a_pc;
    assign o_ir1     = out_sel ? b_ir    : a_ir;
    assign o_brinfo1 = out_sel ? b_br    : a_br;
    assign o_ecode1  = out_sel ? b_ecode : a_ecode;

    assign o_pc2     = out_sel ? a_pc    : b_pc;
    assign o_ir2     = out_sel ? a_ir    : b_ir;
    assign o_brinfo2 = out_sel ? a_br    : b_br;
    assign o_ecode2  = out_sel ? a_ecode : b_ecode;

    // banks never differ by more than one, so lane 1 fills first
    assign o_valid = {a_busy || b_busy, a_busy && b_busy};

    assign o_full = (a_count >= FULL_LVL) || (b_count >= FULL_LVL);

endmodule

`default_nettype wire

// File: hw/iq_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_params.svh"

module iq_bank (
    input  wire logic            clk,
    input  wire logic            rstn,
    input  wire logic            i_flush,

    input  wire logic            i_wr,
    input  wire iq_pkg::pc_t     i_wr_pc,
    input  wire iq_pkg::ir_t     i_wr_ir,
    input  wire iq_pkg::brinfo_t i_wr_br,
    input  wire iq_pkg::ecode_t  i_wr_ecode,

    input  wire logic            i_rd,

    output iq_pkg::pc_t          o_rd_pc,
    output iq_pkg::ir_t          o_rd_ir,
    output iq_pkg::brinfo_t      o_rd_br,
    output iq_pkg::ecode_t       o_rd_ecode,
    output iq_pkg::cnt_t         o_count
);

    localparam iq_pkg::ptr_t PTR_FIRST = iq_pkg::ptr_t'(1);

    iq_pkg::ptr_t    head;
    iq_pkg::ptr_t    tail;
    iq_pkg::cnt_t    count;
    logic            wr_en;

    iq_pkg::pc_t     pc_mem    [`IQ_BANK_DEPTH];
    iq_pkg::ir_t     ir_mem    [`IQ_BANK_DEPTH];
    iq_pkg::brinfo_t br_mem    [`IQ_BANK_DEPTH];
    iq_pkg::ecode_t  ecode_mem [`IQ_BANK_DEPTH];

    // flush wins over a write in the same cycle
    assign wr_en = i_wr && !i_flush;

    ////////////////////
    // pointers and count
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            head  <= PTR_FIRST;
            tail  <= PTR_FIRST;
            count <= '0;
        end else if (i_flush) begin
            head  <= PTR_FIRST;
            tail  <= PTR_FIRST;
            count <= '0;
        end else begin
            // rotate left by one slot
            if (wr_en) begin
                head <= {head[`IQ_BANK_DEPTH-2:0], head[`IQ_BANK_DEPTH-1]};
            end
            if (i_rd) begin
                tail <= {tail[`IQ_BANK_DEPTH-2:0], tail[`IQ_BANK_DEPTH-1]};
            end
            case ({wr_en, i_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////
    // storage
    ////////////////////
    always_ff @(posedge clk) begin
        for (int i = 0; i < `IQ_BANK_DEPTH; i++) begin
            if (wr_en && head[i]) begin
                pc_mem[i]    <= i_wr_pc;
                ir_mem[i]    <= i_wr_ir;
                br_mem[i]    <= i_wr_br;
                ecode_mem[i] <= i_wr_ecode;
            end
        end
    end

    // one-hot select of the tail entry
    always_comb begin
        o_rd_pc    = '0;
        o_rd_ir    = '0;
        o_rd_br    = '0;
        o_rd_ecode = '0;
        for (int i = 0; i < `IQ_BANK_DEPTH; i++) begin
            if (tail[i]) begin
                o_rd_pc    = pc_mem[i];
                o_rd_ir    = ir_mem[i];
                o_rd_br    = br_mem[i];
                o_rd_ecode = ecode_mem[i];
            end
        end
    end

    assign o_count = count;

endmodule

`default_nettype wire

// File: hw/iq_pkg.sv
`default_nettype none

`include "iq_params.svh"

package iq_pkg;

    ////////////////////
    // payload fields
    ////////////////////
    typedef logic [`IQ_PC_W-1:0]    pc_t;
    typedef logic [`IQ_IR_W-1:0]    ir_t;
    // branch type in the top bits, predicted target below
    typedef logic [`IQ_BR_W-1:0]    brinfo_t;
    typedef logic [`IQ_ECODE_W-1:0] ecode_t;

    ////////////////////
    // bank bookkeeping
    ////////////////////
    typedef logic [`IQ_BANK_DEPTH-1:0] ptr_t;
    typedef logic [`IQ_CNT_W-1:0]      cnt_t;

    // write side req/ack slave
    typedef enum logic [1:0] {
        HS_IDLE     = 2'd0,
        HS_ACK      = 2'd1,
        HS_WAIT_LOW = 2'd2
    } hs_state_e;

endpackage

`default_nettype wire

// File: hw/iq_params.svh
`ifndef IQ_PARAMS_SVH
`define IQ_PARAMS_SVH

// entries per bank, pointers are one-hot over this
`define IQ_BANK_DEPTH 16

// payload field widths
`define IQ_PC_W       32
`define IQ_IR_W       32
`define IQ_BR_W       34
`define IQ_ECODE_W    8

// occupancy counter, must hold IQ_BANK_DEPTH
`define IQ_CNT_W      5

`endif
